//--- project.f
source/monitorPkg.sv
source/pcEventDetector.sv
source/eventQueue.sv
source/verdictController.sv
source/coreTestMonitor.sv
test/monitorChecker.sv
test/tbCoreTestMonitor.sv

//--- run.sh
#!/bin/sh
# compile and run the core test monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tbCoreTestMonitor \
  -f project.f \
  -o simCoreTestMonitor

obj_dir/simCoreTestMonitor > sim.log
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

//--- source/coreTestMonitor.sv
`timescale 1ns/1ns

module coreTestMonitor
  import monitorPkg::*;
#(
  parameter int PcWidth       = 64,
  parameter int StuckLimit    = 500,
  parameter int QueueDepth    = 8,
  parameter int HoldOffCycles = 20
) (
  input  logic               dvtFlags,
  input  logic               pcFail,
  input  logic               traceValid,
  input  logic [PcWidth-1:0] tracePc,
  input  logic               cmdValid,
  input  cmdOpT              cmdOp,
  input  slotT               cmdSlot,
  input  logic [31:0]        cmdData,
  output logic               passStatus,
  output logic               failStatus,
  output logic               holdCoreReset,
  output logic               overflow,
  output logic               statusValid,
  output logic [1:0]         statusData
);

  // detector to queue
  logic         eventPush;
  monitorEventT eventIn;

  // queue to controller
  monitorEventT eventOut;
  logic         notEmpty;
  logic         eventPop;

  pcEventDetector #(
    .PcWidth    (PcWidth),
    .StuckLimit (StuckLimit)
  ) detector (
    .dvtFlags   (dvtFlags),
    .pcFail     (pcFail),
    .traceValid (traceValid),
    .tracePc    (tracePc),
    .cmdValid   (cmdValid),
    .cmdOp      (cmdOp),
    .cmdSlot    (cmdSlot),
    .cmdData    (cmdData),
    .eventPush  (eventPush),
    .eventIn    (eventIn)
  );

  eventQueue #(
    .QueueDepth (QueueDepth)
  ) queue (
    .dvtFlags  (dvtFlags),
    .pcFail    (pcFail),
    .eventPush (eventPush),
    .eventIn   (eventIn),
    .eventPop  (eventPop),
    .eventOut  (eventOut),
    .notEmpty  (notEmpty),
    .overflow  (overflow)
  );

  verdictController #(
    .HoldOffCycles (HoldOffCycles)
  ) controller (
    .dvtFlags      (dvtFlags),
    .pcFail        (pcFail),
    .eventOut      (eventOut),
    .notEmpty      (notEmpty),
    .cmdValid      (cmdValid),
    .cmdOp         (cmdOp),
    .eventPop      (eventPop),
    .passStatus    (passStatus),
    .failStatus    (failStatus),
    .holdCoreReset (holdCoreReset),
    .statusValid   (statusValid),
    .statusData    (statusData)
  );

endmodule

//--- source/eventQueue.sv
`timescale 1ns/1ns

module eventQueue
  import monitorPkg::*;
#(
  parameter int QueueDepth = 8
) (
  input  logic         dvtFlags,
  input  logic         pcFail,
  input  logic         eventPush,
  input  monitorEventT eventIn,
  input  logic         eventPop,
  output monitorEventT eventOut,
  output logic         notEmpty,
  output logic         overflow
);

  localparam int PtrWidth = $clog2(QueueDepth);

  monitorEventT        entries [QueueDepth];
  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [PtrWidth:0]   occupancy;
  logic                full;
  logic                doPush;
  logic                doPop;

  assign full     = (occupancy == (PtrWidth + 1)'(QueueDepth));
  assign notEmpty = (occupancy != '0);
  assign doPush   = eventPush && !full;  // dropped when full, even with a pop
  assign doPop    = eventPop && notEmpty;
  assign eventOut = entries[rdPtr];      // head entry

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge dvtFlags) begin
    if (doPush) begin
      entries[wrPtr] <= eventIn;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      occupancy <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;  // none, or both at once
      endcase
    end
  end

  // sticky lost-event flag
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      overflow <= 1'b0;
    end else if (eventPush && full) begin
      overflow <= 1'b1;
    end
  end

  // the controller must gate its pop on notEmpty
  popWhileEmpty : assert property (@(posedge dvtFlags) disable iff (pcFail)
    eventPop |-> notEmpty);

endmodule

//--- source/monitorPkg.sv
package monitorPkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int CompareWidth   = 30;  // low pc bits compared against the table
  localparam int SlotIndexWidth = 2;
  localparam int SlotCount      = 1 << SlotIndexWidth;

  // address table slots
  typedef enum logic [SlotIndexWidth-1:0] {
    slotPass,
    slotFail,
    slotFinish,
    slotFailAlt   // matches only when nonzero, like finish
  } slotT;

  // command opcodes, split between detector and controller
  typedef enum logic [2:0] {
    opNone,
    opWriteSlot,     // detector
    opDisableStuck,  // detector
    opForceFail,     // controller, timeout case
    opReadStatus     // controller
  } cmdOpT;

  typedef enum logic [1:0] {
    evPass,
    evFail,
    evStuck
  } eventKindT;

  // one queue entry, 32 bits
  typedef struct packed {
    eventKindT               kind;
    logic [CompareWidth-1:0] pc;
  } monitorEventT;

endpackage

//--- source/pcEventDetector.sv
`timescale 1ns/1ns

module pcEventDetector
  import monitorPkg::*;
#(
  parameter int PcWidth    = 64,
  parameter int StuckLimit = 500
) (
  input  logic               dvtFlags,
  input  logic               pcFail,
  input  logic               traceValid,
  input  logic [PcWidth-1:0] tracePc,
  input  logic               cmdValid,
  input  cmdOpT              cmdOp,
  input  slotT               cmdSlot,
  input  logic [31:0]        cmdData,
  output logic               eventPush,
  output monitorEventT       eventIn
);

  localparam int CountWidth = $clog2(StuckLimit + 1);

  logic [CompareWidth-1:0] slotTable [SlotCount];
  logic                    stuckDisabled;
  logic [PcWidth-1:0]      lastPc;
  logic [CountWidth-1:0]   repeatCount;
  logic [CountWidth-1:0]   repeatNext;
  logic [CompareWidth-1:0] pcLow;
  logic                    sameAsLast;
  logic                    reachLimit;
  logic                    stuckHit;
  logic                    failHit;
  logic                    passHit;

  // ----------------------------------------
  // match logic
  // ----------------------------------------
  assign pcLow = tracePc[CompareWidth-1:0];

  // finish and failAlt are disabled while zero
  assign failHit = traceValid &&
                   ((pcLow == slotTable[slotFail]) ||
                    ((slotTable[slotFailAlt] != '0) && (pcLow == slotTable[slotFailAlt])));
  assign passHit = traceValid &&
                   ((pcLow == slotTable[slotPass]) ||
                    ((slotTable[slotFinish] != '0) && (pcLow == slotTable[slotFinish])));

  // ----------------------------------------
  // stuck loop
  // ----------------------------------------
  assign sameAsLast = (tracePc == lastPc);  // full pc width here
  assign reachLimit = sameAsLast && (repeatCount == CountWidth'(StuckLimit - 1));
  assign stuckHit   = traceValid && reachLimit && !stuckDisabled;

  always_comb begin
    if (!sameAsLast) begin
      repeatNext = '0;
    end else if (repeatCount == CountWidth'(StuckLimit)) begin
      repeatNext = repeatCount;  // saturate, so only one evStuck
    end else begin
      repeatNext = repeatCount + 1'b1;
    end
  end

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      lastPc      <= '0;
      repeatCount <= '0;
    end else if (traceValid) begin
      lastPc      <= tracePc;
      repeatCount <= repeatNext;
    end
  end

  // address table and stuck disable
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      for (int i = 0; i < SlotCount; i++) begin
        slotTable[i] <= '0;
      end
      stuckDisabled <= 1'b0;
    end else if (cmdValid) begin
      if (cmdOp == opWriteSlot) begin
        slotTable[cmdSlot] <= cmdData[CompareWidth-1:0];
      end
      if (cmdOp == opDisableStuck) begin
        stuckDisabled <= 1'b1;  // sticky until reset
      end
    end
  end

  // ----------------------------------------
  // registered event out
  // ----------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      eventPush <= 1'b0;
    end else begin
      eventPush <= stuckHit || failHit || passHit;
    end
  end

  always_ff @(posedge dvtFlags) begin
    if (traceValid) begin
      eventIn.pc <= pcLow;
      if (stuckHit) begin
        eventIn.kind <= evStuck;  // stuck beats any match
      end else if (failHit) begin
        eventIn.kind <= evFail;   // fail beats pass
      end else begin
        eventIn.kind <= evPass;
      end
    end
  end

  // disable takes effect for retires after the command
  stuckWhileDisabled : assert property (@(posedge dvtFlags) disable iff (pcFail)
    (eventPush && (eventIn.kind == evStuck)) |-> !$past(stuckDisabled));

endmodule

//--- source/verdictController.sv
`timescale 1ns/1ns

module verdictController
  import monitorPkg::*;
#(
  parameter int HoldOffCycles = 20
) (
  input  logic         dvtFlags,
  input  logic         pcFail,
  input  monitorEventT eventOut,
  input  logic         notEmpty,
  input  logic         cmdValid,
  input  cmdOpT        cmdOp,
  output logic         eventPop,
  output logic         passStatus,
  output logic         failStatus,
  output logic         holdCoreReset,
  output logic         statusValid,
  output logic [1:0]   statusData
);

  localparam int HoldWidth = $clog2(HoldOffCycles + 1);

  logic                 counting;   // hold-off countdown running
  logic [HoldWidth-1:0] holdCount;
  logic                 takeVerdict;
  logic                 forceFail;
  logic                 readStatus;

  // stall only during the countdown, drain once held
  assign eventPop    = notEmpty && !counting;
  assign takeVerdict = eventPop && !holdCoreReset;
  assign forceFail   = cmdValid && (cmdOp == opForceFail);
  assign readStatus  = cmdValid && (cmdOp == opReadStatus);

  // ----------------------------------------
  // verdict status
  // ----------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      passStatus <= 1'b0;
      failStatus <= 1'b0;
    end else if (forceFail) begin
      // timeout case, wins over a same-cycle pass
      passStatus <= 1'b0;
      failStatus <= 1'b1;
    end else if (takeVerdict) begin
      if (eventOut.kind == evPass) begin
        passStatus <= 1'b1;
        failStatus <= 1'b0;
      end else begin
        passStatus <= 1'b0;  // fail and stuck alike
        failStatus <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // hold-off and core reset hold
  // ----------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      counting      <= 1'b0;
      holdCount     <= '0;
      holdCoreReset <= 1'b0;
    end else if (counting) begin
      if (holdCount == '0) begin
        counting      <= 1'b0;
        holdCoreReset <= 1'b1;  // stays until reset
      end else begin
        holdCount <= holdCount - 1'b1;
      end
    end else if (takeVerdict) begin
      // first verdict starts the countdown
      counting  <= 1'b1;
      holdCount <= HoldWidth'(HoldOffCycles - 1);
    end
  end

  // ----------------------------------------
  // status read
  // ----------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      statusValid <= 1'b0;
    end else begin
      statusValid <= readStatus;  // one-cycle pulse
    end
  end

  always_ff @(posedge dvtFlags) begin
    if (readStatus) begin
      statusData <= {failStatus, passStatus};
    end
  end

  bothVerdicts : assert property (@(posedge dvtFlags) disable iff (pcFail)
    !(passStatus && failStatus));

endmodule

//--- test/monitorChecker.sv
`timescale 1ns/1ns

module monitorChecker
  import monitorPkg::*;
#(
  parameter int PcWidth       = 64,
  parameter int StuckLimit    = 500,
  parameter int QueueDepth    = 8,
  parameter int HoldOffCycles = 20
) (
  input  logic               dvtFlags,
  input  logic               pcFail,
  input  logic               traceValid,
  input  logic [PcWidth-1:0] tracePc,
  input  logic               cmdValid,
  input  cmdOpT              cmdOp,
  input  slotT               cmdSlot,
  input  logic [31:0]        cmdData,
  input  logic               passStatus,
  input  logic               failStatus,
  input  logic               holdCoreReset,
  input  logic               overflow,
  input  logic               statusValid,
  input  logic [1:0]         statusData,
  input  logic               checkReq,
  input  int                 testId,
  output int                 testCount,
  output int                 errorCount
);

  localparam int HistDepth   = 64;
  localparam int QuietCycles = 60;

  typedef struct packed {
    logic       pass;
    logic       fail;
    logic       overflow;
    logic       hold;
    logic [1:0] readData;
    logic [7:0] reads;
  } expectT;

  // one entry per active cycle since the last reset
  logic               histRetire [HistDepth];
  logic [PcWidth-1:0] histPc     [HistDepth];
  logic               histCmd    [HistDepth];
  cmdOpT              histOp     [HistDepth];
  slotT               histSlot   [HistDepth];
  logic [31:0]        histData   [HistDepth];
  int                 histCycle  [HistDepth];
  int                 histCount;
  int                 cycleNow;
  int                 pulseCount;
  logic [1:0]         pulseData;

  // ----------------------------------------
  // stimulus and response capture
  // ----------------------------------------
  always @(posedge dvtFlags) begin
    cycleNow <= cycleNow + 1;
  end

  always @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      histCount  <= 0;
      pulseCount <= 0;
    end else begin
      if ((traceValid || cmdValid) && (histCount < HistDepth)) begin
        histRetire[histCount] <= traceValid;
        histPc[histCount]     <= tracePc;
        histCmd[histCount]    <= cmdValid;
        histOp[histCount]     <= cmdOp;
        histSlot[histCount]   <= cmdSlot;
        histData[histCount]   <= cmdData;
        histCycle[histCount]  <= cycleNow;
        histCount             <= histCount + 1;
      end
      if (statusValid) begin
        pulseCount <= pulseCount + 1;
        pulseData  <= statusData;
      end
    end
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic expectT predictOutcome();
    logic [CompareWidth-1:0] slots [SlotCount];
    logic [CompareWidth-1:0] low;
    logic [PcWidth-1:0]      prevPc;
    logic                    disabled;
    logic                    started;
    logic                    stuck;
    logic                    failMatch;
    logic                    passMatch;
    int                      repeats;
    int                      firstCycle;
    int                      waiting;
    expectT                  result;
    result     = '0;
    prevPc     = '0;
    disabled   = 1'b0;
    started    = 1'b0;
    repeats    = 0;
    firstCycle = 0;
    waiting    = 0;
    for (int s = 0; s < SlotCount; s++) begin
      slots[s] = '0;
    end
    for (int i = 0; i < histCount; i++) begin
      // retire sees the table as it was before this cycle's command
      if (histRetire[i]) begin
        low   = histPc[i][CompareWidth-1:0];
        stuck = 1'b0;
        if (histPc[i] != prevPc) begin
          repeats = 0;
        end else if (repeats < StuckLimit) begin
          repeats = repeats + 1;
          stuck   = (repeats == StuckLimit) && !disabled;
        end
        prevPc    = histPc[i];
        failMatch = (low == slots[slotFail]) ||
                    ((slots[slotFailAlt] != '0) && (low == slots[slotFailAlt]));
        passMatch = (low == slots[slotPass]) ||
                    ((slots[slotFinish] != '0) && (low == slots[slotFinish]));
        if (stuck || failMatch || passMatch) begin
          if (!started) begin
            started     = 1'b1;  // first event decides, the rest wait or drop
            firstCycle  = histCycle[i];
            result.fail = stuck || failMatch;
            result.pass = !(stuck || failMatch);
          end else if ((histCycle[i] - firstCycle) <= HoldOffCycles) begin
            waiting = waiting + 1;  // queued behind the countdown
            if (waiting > QueueDepth) begin
              result.overflow = 1'b1;
            end
          end
        end
      end
      if (histCmd[i]) begin
        case (histOp[i])
          opWriteSlot:    slots[histSlot[i]] = histData[i][CompareWidth-1:0];
          opDisableStuck: disabled = 1'b1;
          opForceFail: begin
            result.pass = 1'b0;
            result.fail = 1'b1;
          end
          opReadStatus: begin
            result.readData = {result.fail, result.pass};
            result.reads    = result.reads + 1'b1;
          end
          default: ;
        endcase
      end
    end
    result.hold = started;
    return result;
  endfunction

  function automatic string testName(input int id);
    case (id)
      0:       return "passFinish";
      1:       return "zeroFailAltIdle";
      2:       return "failAltSlot";
      3:       return "passFailOverlap";
      4:       return "stuckLoop";
      5:       return "stuckDisabled";
      6:       return "forceFailRead";
      7:       return "holdOffOverflow";
      default: return "unknown";
    endcase
  endfunction

  task automatic compareValue(input string name, input string signal,
                              input int expected, input int actual);
    if (expected != actual) begin
      $display("Fail %s: %s expected %0d actual %0d", name, signal, expected, actual);
      errorCount = errorCount + 1;
    end
  endtask

  task automatic settleAndCompare();
    expectT expected;
    string  name;
    int     quiet;
    int     errorsBefore;
    name         = testName(testId);
    quiet        = 0;
    errorsBefore = errorCount;
    do begin
      @(negedge dvtFlags);
      quiet = quiet + 1;
    end while (!holdCoreReset && (quiet < QuietCycles));
    expected = predictOutcome();
    compareValue(name, "passStatus", int'(expected.pass), int'(passStatus));
    compareValue(name, "failStatus", int'(expected.fail), int'(failStatus));
    compareValue(name, "overflow", int'(expected.overflow), int'(overflow));
    compareValue(name, "holdCoreReset", int'(expected.hold), int'(holdCoreReset));
    compareValue(name, "statusValid pulses", int'(expected.reads), pulseCount);
    if ((expected.reads != '0) && (pulseCount != 0)) begin
      compareValue(name, "statusData", int'(expected.readData), int'(pulseData));
    end
    $display("%s done, %0d mismatches", name, errorCount - errorsBefore);
  endtask

  initial begin
    testCount  = 0;
    errorCount = 0;
    forever begin
      wait (checkReq);
      settleAndCompare();
      testCount = testCount + 1;
      wait (!checkReq);
    end
  end

endmodule

//--- test/tbCoreTestMonitor.sv
`timescale 1ns/1ns

module tbCoreTestMonitor
  import monitorPkg::*;
();

  localparam int PcWidth       = 64;
  localparam int StuckLimit    = 16;
  localparam int QueueDepth    = 4;
  localparam int HoldOffCycles = 20;
  localparam int TestTotal     = 8;
  localparam int TestLength    = 8 + 40 + 62;  // reset, stimulus, settle window
  localparam int CycleLimit    = 2 * TestTotal * TestLength;

  logic                    dvtFlags;
  logic                    pcFail;
  logic                    traceValid;
  logic [PcWidth-1:0]      tracePc;
  logic                    cmdValid;
  cmdOpT                   cmdOp;
  slotT                    cmdSlot;
  logic [31:0]             cmdData;
  logic                    passStatus;
  logic                    failStatus;
  logic                    holdCoreReset;
  logic                    overflow;
  logic                    statusValid;
  logic [1:0]              statusData;
  logic                    checkReq;
  int                      testId;
  int                      testsDone;
  int                      errorCount;
  int                      cycleCount;
  logic [31:0]             lfsrState;
  logic [CompareWidth-1:0] slotCopy [SlotCount];  // addresses random pcs avoid
  logic [PcWidth-1:0]      loopPc;

  coreTestMonitor #(
    .PcWidth       (PcWidth),
    .StuckLimit    (StuckLimit),
    .QueueDepth    (QueueDepth),
    .HoldOffCycles (HoldOffCycles)
  ) uut (
    .dvtFlags      (dvtFlags),
    .pcFail        (pcFail),
    .traceValid    (traceValid),
    .tracePc       (tracePc),
    .cmdValid      (cmdValid),
    .cmdOp         (cmdOp),
    .cmdSlot       (cmdSlot),
    .cmdData       (cmdData),
    .passStatus    (passStatus),
    .failStatus    (failStatus),
    .holdCoreReset (holdCoreReset),
    .overflow      (overflow),
    .statusValid   (statusValid),
    .statusData    (statusData)
  );

  monitorChecker #(
    .PcWidth       (PcWidth),
    .StuckLimit    (StuckLimit),
    .QueueDepth    (QueueDepth),
    .HoldOffCycles (HoldOffCycles)
  ) resultChecker (
    .dvtFlags      (dvtFlags),
    .pcFail        (pcFail),
    .traceValid    (traceValid),
    .tracePc       (tracePc),
    .cmdValid      (cmdValid),
    .cmdOp         (cmdOp),
    .cmdSlot       (cmdSlot),
    .cmdData       (cmdData),
    .passStatus    (passStatus),
    .failStatus    (failStatus),
    .holdCoreReset (holdCoreReset),
    .overflow      (overflow),
    .statusValid   (statusValid),
    .statusData    (statusData),
    .checkReq      (checkReq),
    .testId        (testId),
    .testCount     (testsDone),
    .errorCount    (errorCount)
  );

  initial begin
    dvtFlags = 1'b0;
    forever #10 dvtFlags = ~dvtFlags;
  end

  always @(posedge dvtFlags) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout after %0d cycles, a test never finished", cycleCount);
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic drawPc(output logic [PcWidth-1:0] pc);
    logic clash;
    do begin
      for (int b = 0; b < PcWidth; b++) begin
        pc[b]     = lfsrState[0];  // one step per bit
        lfsrState = lfsrNext(lfsrState);
      end
      clash = (pc[CompareWidth-1:0] == '0);  // zero slots still match
      for (int s = 0; s < SlotCount; s++) begin
        if (pc[CompareWidth-1:0] == slotCopy[s]) begin
          clash = 1'b1;
        end
      end
    end while (clash);
  endtask

  task automatic applyReset();
    pcFail = 1'b1;
    for (int s = 0; s < SlotCount; s++) begin
      slotCopy[s] = '0;
    end
    repeat (8) @(negedge dvtFlags);
    pcFail = 1'b0;
  endtask

  task automatic issueCommand(input cmdOpT op, input slotT slot, input logic [31:0] data);
    cmdValid = 1'b1;
    cmdOp    = op;
    cmdSlot  = slot;
    cmdData  = data;
    if (op == opWriteSlot) begin
      slotCopy[slot] = data[CompareWidth-1:0];
    end
    @(negedge dvtFlags);
    cmdValid = 1'b0;
    cmdOp    = opNone;
  endtask

  task automatic retirePc(input logic [PcWidth-1:0] pc);
    traceValid = 1'b1;
    tracePc    = pc;
    @(negedge dvtFlags);
    traceValid = 1'b0;
  endtask

  task automatic runCheck(input int id);
    testId   = id;
    checkReq = 1'b1;
    wait (testsDone == id + 1);
    @(negedge dvtFlags);
    checkReq = 1'b0;
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    pcFail     = 1'b1;
    traceValid = 1'b0;
    tracePc    = '0;
    cmdValid   = 1'b0;
    cmdOp      = opNone;
    cmdSlot    = slotPass;
    cmdData    = '0;
    checkReq   = 1'b0;
    testId     = 0;
    lfsrState  = 32'h175a5e71;

    applyReset();
    issueCommand(opWriteSlot, slotPass, 32'h0000_1000);
    issueCommand(opWriteSlot, slotFinish, 32'hC000_2000);  // top bits not compared
    repeat (8) begin
      drawPc(loopPc);
      retirePc(loopPc);
    end
    retirePc(64'h1234_5678_4000_2000);
    runCheck(0);

    applyReset();
    issueCommand(opWriteSlot, slotPass, 32'h0000_1100);
    issueCommand(opWriteSlot, slotFail, 32'h0000_1200);
    retirePc('0);  // failAlt still zero
    runCheck(1);
    issueCommand(opWriteSlot, slotFailAlt, 32'h0000_1300);
    retirePc(64'h1300);
    runCheck(2);

    applyReset();
    issueCommand(opWriteSlot, slotPass, 32'h0000_1400);
    issueCommand(opWriteSlot, slotFail, 32'h0000_1400);
    retirePc(64'h1400);
    runCheck(3);

    applyReset();
    drawPc(loopPc);
    repeat (StuckLimit + 1) retirePc(loopPc);
    runCheck(4);

    applyReset();
    issueCommand(opDisableStuck, slotPass, '0);
    repeat (StuckLimit + 1) retirePc(loopPc);
    runCheck(5);

    applyReset();
    issueCommand(opForceFail, slotPass, '0);
    issueCommand(opReadStatus, slotPass, '0);
    runCheck(6);

    // first retire starts the hold-off, the rest pile up in the queue
    applyReset();
    issueCommand(opWriteSlot, slotPass, 32'h0000_1500);
    retirePc(64'h1500);
    repeat (10) retirePc(64'h1500);
    runCheck(7);

    $display("%0d tests checked, %0d errors", testsDone, errorCount);
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
